// File: dv/l1d_stage_d1_assert.sv
module l1d_stage_d1_assert #(
  parameter int unsigned LA_W   = l1d_pkg::TAG_W + l1d_pkg::IDX_W,
  parameter int unsigned LINE_W = l1d_pkg::LINE_WORDS * l1d_pkg::WORD_W
) (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              l2_req_i,
  input logic              l2_we_i,
  input logic [LA_W-1:0]   l2_addr_i,
  input logic [LINE_W-1:0] l2_wdata_i,
  input logic              l2_ack_i,
  input logic              ans_valid_i,   // Load answer strobe
  input logic              fill_done_i    // Fill answer strobe
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;  // Failed assertions so far

  // Payload frozen while the request waits for ack
  l2_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    l2_req_i && !l2_ack_i |=>
      l2_req_i && $stable(l2_addr_i) && $stable(l2_we_i) && $stable(l2_wdata_i))
    else begin
      $error("L2 request dropped or changed before ack");
      fail_cnt++;
    end

  // Both answers come from one accepted request, never together
  ans_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(ans_valid_i && fill_done_i))
    else begin
      $error("Load answer and fill answer in the same cycle");
      fail_cnt++;
    end

  // Return to zero before a new request
  l2_rise: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(l2_req_i) |-> !l2_ack_i)
    else begin
      $error("L2 request raised while ack still high");
      fail_cnt++;
    end

endmodule

bind l1d_stage_d1 l1d_stage_d1_assert #(
  .LA_W(LA_W), .LINE_W(LINE_W)
) i_l1d_stage_d1_assert (
  .clk_i, .rst_ni,
  .l2_req_i(l2_req_o), .l2_we_i(l2_we_o), .l2_addr_i(l2_addr_o),
  .l2_wdata_i(l2_wdata_o), .l2_ack_i,
  .ans_valid_i(ans_valid_o), .fill_done_i(fill_done_o)
);

// File: dv/tb_l1d_stage_d1.sv
module tb_l1d_stage_d1;

  timeunit 1ns;
  timeprecision 100ps;

  import l1d_pkg::*;

  localparam int unsigned CLK_PERIOD   = 8;
  localparam int unsigned RESET_CYCLES = 16;
  localparam int unsigned WAIT_LIMIT   = 200;   // Cycles for any single wait
  localparam int unsigned RUN_CYCLES   = 2500;  // About 400 cycles per test plus margin

  logic              clk_i, rst_ni;
  logic              req_valid_i, req_rdy_o;
  req_kind_e         req_kind_i;
  tag_t              req_tag_i;
  idx_t              req_idx_i;
  off_t              req_off_i;
  tag_t  [N_WAY-1:0] way_tag_i;
  logic  [N_WAY-1:0] way_valid_i, way_dirty_i;
  line_t [N_WAY-1:0] way_line_i;
  logic              ans_valid_o, ans_miss_o, fill_done_o;
  word_t             ans_data_o;
  way_t              fill_way_o;
  logic              l2_req_o, l2_we_o, l2_ack_i;
  line_addr_t        l2_addr_o;
  line_t             l2_wdata_o;

  int unsigned n_errors = 0, n_timeouts = 0, assert_fails;
  int unsigned ack_delay;          // Cycles from request to ack
  logic        ack_hold;           // Withholds ack while set
  logic        l2_log_we [$];      // Every L2 request seen
  line_addr_t  l2_log_addr [$];
  line_t       l2_log_data [$];
  logic        got_valid, got_miss, got_fill_done;  // Outputs one cycle after acceptance
  word_t       got_data;
  way_t        got_fill_way;
  logic [31:0] lcg_state = 32'hd372_45cf;

  l1d_stage_d1 #(
    .N_WAY(N_WAY), .IDX_W(IDX_W), .TAG_W(TAG_W), .LINE_WORDS(LINE_WORDS),
    .MSHR_ENTRIES(MSHR_ENTRIES), .WBB_ENTRIES(WBB_ENTRIES)
  ) i_l1d_stage_d1 (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic word_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic line_t rand_line();
    line_t l;
    for (int w = 0; w < LINE_WORDS; w++) begin
      l[w*WORD_W +: WORD_W] = next_rand();
    end
    return l;
  endfunction

  // Word 0 sits in the low bits of a line
  function automatic word_t word_of(line_t l, off_t off);
    return l[off*WORD_W +: WORD_W];
  endfunction

  task automatic report_mismatch(input string test, input string what,
                                 input line_t exp, input line_t act);
    $display("CHECK FAILED %s %s: expected %0h, actual %0h", test, what, exp, act);
    n_errors++;
  endtask

  // Indexed set as the array-read stage would present it
  task automatic load_set(input tag_t base, input logic [N_WAY-1:0] valid,
                          input logic [N_WAY-1:0] dirty);
    for (int w = 0; w < N_WAY; w++) begin
      way_tag_i[w]  = base + tag_t'(w);
      way_line_i[w] = rand_line();
    end
    way_valid_i = valid;
    way_dirty_i = dirty;
  endtask

  // Holds one request until ready and captures the outputs one cycle after acceptance
  task automatic do_req(input req_kind_e kind, input tag_t tag, input idx_t idx, input off_t off);
    int unsigned n = 0;
    req_kind_i  = kind;
    req_tag_i   = tag;
    req_idx_i   = idx;
    req_off_i   = off;
    req_valid_i = 1'b1;
    #1;
    while (req_rdy_o !== 1'b1 && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      #1;
      n++;
    end
    if (req_rdy_o !== 1'b1) begin
      $display("ERROR: %s request not accepted within %0d cycles", kind.name(), WAIT_LIMIT);
      n_timeouts++;
    end
    @(negedge clk_i);            // Accepted on the rising edge just passed
    req_valid_i   = 1'b0;
    got_valid     = ans_valid_o;
    got_miss      = ans_miss_o;
    got_data      = ans_data_o;
    got_fill_done = fill_done_o;
    got_fill_way  = fill_way_o;
  endtask

  // Waits for a number of logged L2 requests and a quiet bus
  task automatic wait_l2(input int unsigned count, input string test);
    int unsigned n = 0;
    while ((l2_log_we.size() < count || l2_req_o || l2_ack_i) && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      #1;
      n++;
    end
    if (l2_log_we.size() < count || l2_req_o || l2_ack_i) begin
      $display("ERROR: %s expected %0d L2 requests and an idle bus, saw %0d requests",
               test, count, l2_log_we.size());
      n_timeouts++;
    end
  endtask

  task automatic clear_l2_log();
    l2_log_we.delete();
    l2_log_addr.delete();
    l2_log_data.delete();
  endtask

  // L2 side of the four-phase handshake
  task automatic serve_l2();
    @(negedge clk_i);
    if (l2_req_o === 1'b1) begin
      l2_log_we.push_back(l2_we_o);
      l2_log_addr.push_back(l2_addr_o);
      l2_log_data.push_back(l2_wdata_o);
      repeat (ack_delay) @(negedge clk_i);
      while (ack_hold) @(negedge clk_i);
      l2_ack_i = 1'b1;
      do @(negedge clk_i); while (l2_req_o === 1'b1);
      l2_ack_i = 1'b0;           // Release only after req dropped
    end
  endtask

  initial begin
    forever begin
      serve_l2();
    end
  end

  task automatic test_load_hit();
    word_t exp;
    load_set(8'h10, 4'b1111, 4'b0000);  // Only way 2 carries tag 8'h12
    exp = word_of(way_line_i[2], 2'd1);
    do_req(LOAD, 8'h12, 4'd3, 2'd1);
    if (got_valid !== 1'b1) report_mismatch("load_hit", "ans_valid", 1, line_t'(got_valid));
    if (got_miss !== 1'b0) report_mismatch("load_hit", "ans_miss", 0, line_t'(got_miss));
    if (got_data !== exp) report_mismatch("load_hit", "ans_data", line_t'(exp), line_t'(got_data));
  endtask

  task automatic test_load_miss_merge();
    ack_delay = 3;
    clear_l2_log();
    load_set(8'h20, 4'b0000, 4'b0000);
    do_req(LOAD, 8'h40, 4'd5, 2'd0);
    if (got_miss !== 1'b1)
      report_mismatch("load_miss_merge", "first ans_miss", 1, line_t'(got_miss));
    do_req(LOAD, 8'h40, 4'd5, 2'd3);   // Same line merges into the entry
    if (got_miss !== 1'b1)
      report_mismatch("load_miss_merge", "second ans_miss", 1, line_t'(got_miss));
    wait_l2(1, "load_miss_merge");
    repeat (10) @(negedge clk_i);      // Window for a second read that must not come
    if (l2_log_we.size() != 1)
      report_mismatch("load_miss_merge", "L2 request count", 1, line_t'(l2_log_we.size()));
    if (l2_log_we[0] !== 1'b0)
      report_mismatch("load_miss_merge", "l2_we", 0, line_t'(l2_log_we[0]));
    if (l2_log_addr[0] !== {8'h40, 4'd5})
      report_mismatch("load_miss_merge", "l2_addr", line_t'({8'h40, 4'd5}),
                      line_t'(l2_log_addr[0]));
    do_req(FILL, 8'h40, 4'd5, 2'd0);
    if (got_fill_done !== 1'b1)
      report_mismatch("load_miss_merge", "fill_done", 1, line_t'(got_fill_done));
    if (got_fill_way !== 2'd0)
      report_mismatch("load_miss_merge", "fill_way", 0, line_t'(got_fill_way));
    do_req(LOAD, 8'h40, 4'd5, 2'd0);   // Freed entry gives a fresh read
    wait_l2(2, "load_miss_merge");
    if (l2_log_addr[1] !== {8'h40, 4'd5})
      report_mismatch("load_miss_merge", "l2_addr after fill", line_t'({8'h40, 4'd5}),
                      line_t'(l2_log_addr[1]));
    do_req(FILL, 8'h40, 4'd5, 2'd0);
  endtask

  task automatic test_mshr_full();
    line_addr_t exp_addr [4];
    exp_addr = '{{8'h50, 4'd6}, {8'h52, 4'd6}, {8'h53, 4'd6}, {8'h54, 4'd6}};
    ack_delay = 1;
    ack_hold  = 1'b1;
    clear_l2_log();
    load_set(8'h30, 4'b0000, 4'b0000);
    for (int t = 0; t < MSHR_ENTRIES; t++) begin
      do_req(LOAD, 8'h50 + tag_t'(t), 4'd6, 2'd0);
    end
    #1;
    if (req_rdy_o !== 1'b0)
      report_mismatch("mshr_full", "load ready when full", 0, line_t'(req_rdy_o));
    @(negedge clk_i);
    do_req(FILL, 8'h51, 4'd6, 2'd0);   // Buffer has room and the fill frees one entry
    if (got_fill_done !== 1'b1)
      report_mismatch("mshr_full", "fill_done", 1, line_t'(got_fill_done));
    req_kind_i = LOAD;
    #1;
    if (req_rdy_o !== 1'b1)
      report_mismatch("mshr_full", "load ready after fill", 1, line_t'(req_rdy_o));
    @(negedge clk_i);
    do_req(LOAD, 8'h54, 4'd6, 2'd0);
    ack_hold = 1'b0;
    wait_l2(4, "mshr_full");
    for (int i = 0; i < 4; i++) begin  // Oldest pending first and the freed line never sent
      if (l2_log_addr[i] !== exp_addr[i])
        report_mismatch("mshr_full", $sformatf("read %0d address", i),
                        line_t'(exp_addr[i]), line_t'(l2_log_addr[i]));
    end
    for (int i = 0; i < 4; i++) begin
      do_req(FILL, exp_addr[i][IDX_W +: TAG_W], 4'd6, 2'd0);
    end
  endtask

  task automatic test_fifo_victim_evict();
    line_t victim;
    ack_delay = 2;
    clear_l2_log();
    load_set(8'h60, 4'b0000, 4'b0000);
    for (int t = 0; t < N_WAY; t++) begin
      do_req(FILL, 8'h70 + tag_t'(t), 4'd9, 2'd0);
      if (got_fill_way !== way_t'(t))
        report_mismatch("fifo_victim_evict", "fill_way", line_t'(t), line_t'(got_fill_way));
    end
    load_set(8'h60, 4'b1111, 4'b0001);  // Way 0 comes round again as a dirty victim
    victim = way_line_i[0];
    do_req(FILL, 8'h74, 4'd9, 2'd0);
    if (got_fill_way !== 2'd0)
      report_mismatch("fifo_victim_evict", "wrap fill_way", 0, line_t'(got_fill_way));
    wait_l2(1, "fifo_victim_evict");
    if (l2_log_we[0] !== 1'b1)
      report_mismatch("fifo_victim_evict", "l2_we", 1, line_t'(l2_log_we[0]));
    if (l2_log_addr[0] !== {8'h60, 4'd9})
      report_mismatch("fifo_victim_evict", "l2_addr", line_t'({8'h60, 4'd9}),
                      line_t'(l2_log_addr[0]));
    if (l2_log_data[0] !== victim)
      report_mismatch("fifo_victim_evict", "l2_wdata", victim, l2_log_data[0]);
  endtask

  task automatic test_wbb_forward();
    line_t victim;
    ack_delay = 1;
    ack_hold  = 1'b1;                   // Victim stays in the buffer
    clear_l2_log();
    load_set(8'h80, 4'b0001, 4'b0001);
    victim = way_line_i[0];
    do_req(FILL, 8'h88, 4'd10, 2'd0);
    load_set(8'h90, 4'b0000, 4'b0000);  // Load misses in the ways
    do_req(LOAD, 8'h80, 4'd10, 2'd3);
    if (got_miss !== 1'b0) report_mismatch("wbb_forward", "ans_miss", 0, line_t'(got_miss));
    if (got_data !== word_of(victim, 2'd3))
      report_mismatch("wbb_forward", "ans_data", line_t'(word_of(victim, 2'd3)), line_t'(got_data));
    ack_hold = 1'b0;
    wait_l2(1, "wbb_forward");
    if (l2_log_we[0] !== 1'b1) report_mismatch("wbb_forward", "l2_we", 1, line_t'(l2_log_we[0]));
  endtask

  task automatic test_arb_priority();
    line_t      line_a, line_b;
    logic [3:0] exp_we;
    line_addr_t exp_addr [4];
    exp_we   = 4'b1010;                 // Read, write, read, write
    exp_addr = '{{8'h90, 4'd11}, {8'ha0, 4'd12}, {8'h91, 4'd11}, {8'ha1, 4'd12}};
    ack_delay = 1;
    ack_hold  = 1'b1;
    clear_l2_log();
    load_set(8'h20, 4'b0000, 4'b0000);
    do_req(LOAD, 8'h90, 4'd11, 2'd0);   // Goes out and stalls on ack
    do_req(LOAD, 8'h91, 4'd11, 2'd0);   // Stays pending
    load_set(8'ha0, 4'b0011, 4'b0011);
    line_a = way_line_i[0];
    line_b = way_line_i[1];
    do_req(FILL, 8'hb0, 4'd12, 2'd0);
    do_req(FILL, 8'hb1, 4'd12, 2'd0);   // Buffer now full
    ack_hold = 1'b0;
    wait_l2(4, "arb_priority");
    for (int i = 0; i < 4; i++) begin
      if (l2_log_we[i] !== exp_we[i])
        report_mismatch("arb_priority", $sformatf("request %0d l2_we", i),
                        line_t'(exp_we[i]), line_t'(l2_log_we[i]));
      if (l2_log_addr[i] !== exp_addr[i])
        report_mismatch("arb_priority", $sformatf("request %0d l2_addr", i),
                        line_t'(exp_addr[i]), line_t'(l2_log_addr[i]));
    end
    if (l2_log_data[1] !== line_a)
      report_mismatch("arb_priority", "first write data", line_a, l2_log_data[1]);
    if (l2_log_data[3] !== line_b)
      report_mismatch("arb_priority", "second write data", line_b, l2_log_data[3]);
  endtask

  initial begin
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_kind_i  = LOAD;
    req_tag_i   = '0;
    req_idx_i   = '0;
    req_off_i   = '0;
    way_tag_i   = '0;
    way_valid_i = '0;
    way_dirty_i = '0;
    way_line_i  = '0;
    l2_ack_i    = 1'b0;
    ack_delay   = 2;
    ack_hold    = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    test_load_hit();
    test_load_miss_merge();
    test_mshr_full();
    test_fifo_victim_evict();
    test_wbb_forward();
    test_arb_priority();
    assert_fails = i_l1d_stage_d1.i_l1d_stage_d1_assert.fail_cnt;
    $display("Result: %0d wrong values, %0d timeouts, %0d assertion failures",
             n_errors, n_timeouts, assert_fails);
    if (n_errors == 0 && n_timeouts == 0 && assert_fails == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Hard stop in case a wait never ends
  initial begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("ERROR: watchdog expired after %0d ns, tests did not finish", RUN_CYCLES * CLK_PERIOD);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: hdl/d1_lookup.sv
module d1_lookup #(
  parameter  int unsigned N_WAY      = l1d_pkg::N_WAY,
  parameter  int unsigned IDX_W      = l1d_pkg::IDX_W,
  parameter  int unsigned TAG_W      = l1d_pkg::TAG_W,
  parameter  int unsigned LINE_WORDS = l1d_pkg::LINE_WORDS,
  localparam int unsigned OFF_W      = $clog2(LINE_WORDS),
  localparam int unsigned LINE_W     = LINE_WORDS * l1d_pkg::WORD_W
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         req_valid_i,
  input  l1d_pkg::req_kind_e           req_kind_i,
  input  logic [TAG_W-1:0]             req_tag_i,
  input  logic [IDX_W-1:0]             req_idx_i,
  input  logic [OFF_W-1:0]             req_off_i,
  input  logic [N_WAY-1:0][TAG_W-1:0]  way_tag_i,
  input  logic [N_WAY-1:0]             way_valid_i,
  input  logic [N_WAY-1:0][LINE_W-1:0] way_line_i,
  input  logic                         mshr_full_i,
  input  logic                         wbb_full_i,
  input  logic                         wbb_hit_i,    // Line waits in the victim buffer
  input  logic [LINE_W-1:0]            wbb_line_i,
  output logic                         req_rdy_o,
  output logic [TAG_W+IDX_W-1:0]       line_addr_o,
  output logic                         accept_load_miss_o,
  output logic                         accept_fill_o,
  output logic                         ans_valid_o,
  output logic                         ans_miss_o,
  output l1d_pkg::word_t               ans_data_o
);

  import l1d_pkg::*;

  logic [N_WAY-1:0]  hit_vec;
  logic              cache_hit, accept, accept_load;
  logic [LINE_W-1:0] hit_line, sel_line;

  // Tag compare on every valid way, then pick the line that hit
  always_comb begin
    hit_line = '0;
    for (int w = 0; w < N_WAY; w++) begin
      hit_vec[w] = way_valid_i[w] && (way_tag_i[w] == req_tag_i);
      if (hit_vec[w]) begin
        hit_line = way_line_i[w];
      end
    end
  end

  assign cache_hit = |hit_vec;
  assign sel_line  = cache_hit ? hit_line : wbb_line_i;  // Ways first, buffer second
  assign line_addr_o = {req_tag_i, req_idx_i};

  // Loads wait on a free MSHR slot, fills on a free buffer slot
  assign req_rdy_o   = (req_kind_i == LOAD) ? !mshr_full_i : !wbb_full_i;
  assign accept      = req_valid_i && req_rdy_o;
  assign accept_load = accept && (req_kind_i == LOAD);
  assign accept_fill_o      = accept && (req_kind_i == FILL);
  assign accept_load_miss_o = accept_load && !cache_hit && !wbb_hit_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ans_valid_o <= 1'b0;
    end else begin
      ans_valid_o <= accept_load;  // One-cycle pulse
    end
  end

  // Answer payload
  always_ff @(posedge clk_i) begin
    if (accept_load) begin
      ans_miss_o <= !(cache_hit || wbb_hit_i);
      ans_data_o <= sel_line[req_off_i*WORD_W +: WORD_W];
    end
  end

endmodule

// File: hdl/fifo_replacement.sv
module fifo_replacement #(
  parameter  int unsigned N_WAY      = l1d_pkg::N_WAY,
  parameter  int unsigned IDX_W      = l1d_pkg::IDX_W,
  parameter  int unsigned TAG_W      = l1d_pkg::TAG_W,
  parameter  int unsigned LINE_WORDS = l1d_pkg::LINE_WORDS,
  localparam int unsigned WAY_W      = $clog2(N_WAY),
  localparam int unsigned LINE_W     = LINE_WORDS * l1d_pkg::WORD_W
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         fill_i,       // Accepted FILL
  input  logic [IDX_W-1:0]             idx_i,
  input  logic [N_WAY-1:0][TAG_W-1:0]  way_tag_i,
  input  logic [N_WAY-1:0]             way_valid_i,
  input  logic [N_WAY-1:0]             way_dirty_i,
  input  logic [N_WAY-1:0][LINE_W-1:0] way_line_i,
  output logic                         evict_o,
  output logic [TAG_W+IDX_W-1:0]       evict_addr_o,
  output logic [LINE_W-1:0]            evict_line_o,
  output logic                         fill_done_o,
  output logic [WAY_W-1:0]             fill_way_o
);

  logic [WAY_W-1:0] ptr_q [2**IDX_W];  // Next victim of each set
  logic [WAY_W-1:0] victim;

  assign victim = ptr_q[idx_i];

  // Dirty victim leaves for the buffer in the fill cycle
  assign evict_o      = fill_i && way_valid_i[victim] && way_dirty_i[victim];
  assign evict_addr_o = {way_tag_i[victim], idx_i};
  assign evict_line_o = way_line_i[victim];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < 2**IDX_W; s++) begin
        ptr_q[s] <= '0;
      end
      fill_done_o <= 1'b0;
    end else begin
      fill_done_o <= fill_i;
      if (fill_i) begin  // Round robin inside the set
        ptr_q[idx_i] <= (victim == WAY_W'(N_WAY - 1)) ? '0 : victim + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_i) begin
      fill_way_o <= victim;
    end
  end

endmodule

// File: hdl/l1d_pkg.sv
package l1d_pkg;

  // Cache geometry
  localparam int unsigned N_WAY        = 4;
  localparam int unsigned IDX_W        = 4;   // 16 sets
  localparam int unsigned TAG_W        = 8;
  localparam int unsigned WORD_W       = 32;
  localparam int unsigned LINE_WORDS   = 4;
  localparam int unsigned OFF_W        = 2;   // Word offset inside a line
  localparam int unsigned MSHR_ENTRIES = 4;
  localparam int unsigned WBB_ENTRIES  = 2;

  // Address fields
  typedef logic [TAG_W-1:0]             tag_t;
  typedef logic [IDX_W-1:0]             idx_t;
  typedef logic [OFF_W-1:0]             off_t;
  typedef logic [TAG_W+IDX_W-1:0]       line_addr_t;  // {tag, idx}

  // Payload
  typedef logic [WORD_W-1:0]            word_t;
  typedef logic [LINE_WORDS*WORD_W-1:0] line_t;       // Word 0 in the low bits
  typedef logic [$clog2(N_WAY)-1:0]     way_t;

  typedef enum logic {
    LOAD = 1'b0,
    FILL = 1'b1
  } req_kind_e;

  // L2 bus handshake FSM
  typedef enum logic [1:0] {
    IDLE         = 2'd0,
    WAIT_ACK     = 2'd1,  // Request raised, waiting for ack
    WAIT_RELEASE = 2'd2   // Ack seen, waiting for it to drop
  } l2_arb_state_e;

endpackage

// File: hdl/l1d_stage_d1.sv
module l1d_stage_d1 #(
  parameter  int unsigned N_WAY        = l1d_pkg::N_WAY,
  parameter  int unsigned IDX_W        = l1d_pkg::IDX_W,
  parameter  int unsigned TAG_W        = l1d_pkg::TAG_W,
  parameter  int unsigned LINE_WORDS   = l1d_pkg::LINE_WORDS,
  parameter  int unsigned MSHR_ENTRIES = l1d_pkg::MSHR_ENTRIES,
  parameter  int unsigned WBB_ENTRIES  = l1d_pkg::WBB_ENTRIES,
  localparam int unsigned OFF_W        = $clog2(LINE_WORDS),
  localparam int unsigned WAY_W        = $clog2(N_WAY),
  localparam int unsigned LA_W         = TAG_W + IDX_W,
  localparam int unsigned LINE_W       = LINE_WORDS * l1d_pkg::WORD_W
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Request from the array-read stage
  input  logic                           req_valid_i,
  input  l1d_pkg::req_kind_e             req_kind_i,
  input  logic [TAG_W-1:0]               req_tag_i,
  input  logic [IDX_W-1:0]               req_idx_i,
  input  logic [OFF_W-1:0]               req_off_i,
  input  logic [N_WAY-1:0][TAG_W-1:0]    way_tag_i,   // Whole indexed set
  input  logic [N_WAY-1:0]               way_valid_i,
  input  logic [N_WAY-1:0]               way_dirty_i,
  input  logic [N_WAY-1:0][LINE_W-1:0]   way_line_i,
  output logic                           req_rdy_o,
  // Load answer
  output logic                           ans_valid_o,
  output logic                           ans_miss_o,
  output l1d_pkg::word_t                 ans_data_o,
  // Fill answer
  output logic                           fill_done_o,
  output logic [WAY_W-1:0]               fill_way_o,
  // L2 request bus
  output logic                           l2_req_o,
  output logic                           l2_we_o,
  output logic [LA_W-1:0]                l2_addr_o,
  output logic [LINE_W-1:0]              l2_wdata_o,
  input  logic                           l2_ack_i
);

  logic              accept_load_miss, accept_fill;
  logic [LA_W-1:0]   req_line_addr;              // {tag, idx} of the current request
  // MSHR side
  logic              mshr_full, mshr_pend, mshr_grant;
  logic [LA_W-1:0]   mshr_addr;
  // Victim path into the buffer
  logic              evict;
  logic [LA_W-1:0]   evict_addr;
  logic [LINE_W-1:0] evict_line;
  // Buffer side
  logic              wbb_full, wbb_hit, wbb_pend, wbb_grant;
  logic [LINE_W-1:0] wbb_hit_line, wbb_line;
  logic [LA_W-1:0]   wbb_addr;

  d1_lookup #(
    .N_WAY(N_WAY), .IDX_W(IDX_W), .TAG_W(TAG_W), .LINE_WORDS(LINE_WORDS)
  ) i_d1_lookup (
    .clk_i, .rst_ni, .req_valid_i, .req_kind_i, .req_tag_i, .req_idx_i, .req_off_i,
    .way_tag_i, .way_valid_i, .way_line_i,
    .mshr_full_i(mshr_full), .wbb_full_i(wbb_full),
    .wbb_hit_i(wbb_hit), .wbb_line_i(wbb_hit_line),
    .req_rdy_o, .line_addr_o(req_line_addr),
    .accept_load_miss_o(accept_load_miss), .accept_fill_o(accept_fill),
    .ans_valid_o, .ans_miss_o, .ans_data_o
  );

  fifo_replacement #(
    .N_WAY(N_WAY), .IDX_W(IDX_W), .TAG_W(TAG_W), .LINE_WORDS(LINE_WORDS)
  ) i_fifo_replacement (
    .clk_i, .rst_ni, .fill_i(accept_fill), .idx_i(req_idx_i),
    .way_tag_i, .way_valid_i, .way_dirty_i, .way_line_i,
    .evict_o(evict), .evict_addr_o(evict_addr), .evict_line_o(evict_line),
    .fill_done_o, .fill_way_o
  );

  miss_status_regs #(
    .ENTRIES(MSHR_ENTRIES), .LA_W(LA_W)
  ) i_miss_status_regs (
    .clk_i, .rst_ni, .alloc_i(accept_load_miss), .fill_i(accept_fill),
    .line_addr_i(req_line_addr), .grant_i(mshr_grant),
    .full_o(mshr_full), .pend_o(mshr_pend), .pend_addr_o(mshr_addr)
  );

  wb_victim_buffer #(
    .ENTRIES(WBB_ENTRIES), .LA_W(LA_W), .LINE_W(LINE_W)
  ) i_wb_victim_buffer (
    .clk_i, .rst_ni, .push_i(evict), .push_addr_i(evict_addr), .push_line_i(evict_line),
    .lookup_addr_i(req_line_addr), .grant_i(wbb_grant),
    .full_o(wbb_full), .hit_o(wbb_hit), .hit_line_o(wbb_hit_line),
    .pend_o(wbb_pend), .pend_addr_o(wbb_addr), .pend_line_o(wbb_line)
  );

  l2_req_arbiter #(
    .LA_W(LA_W), .LINE_W(LINE_W)
  ) i_l2_req_arbiter (
    .clk_i, .rst_ni, .mshr_pend_i(mshr_pend), .mshr_addr_i(mshr_addr),
    .wbb_pend_i(wbb_pend), .wbb_full_i(wbb_full), .wbb_addr_i(wbb_addr),
    .wbb_line_i(wbb_line), .l2_ack_i,
    .mshr_grant_o(mshr_grant), .wbb_grant_o(wbb_grant),
    .l2_req_o, .l2_we_o, .l2_addr_o, .l2_wdata_o
  );

endmodule

// File: hdl/l2_req_arbiter.sv
module l2_req_arbiter #(
  parameter int unsigned LA_W   = l1d_pkg::TAG_W + l1d_pkg::IDX_W,
  parameter int unsigned LINE_W = l1d_pkg::LINE_WORDS * l1d_pkg::WORD_W
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              mshr_pend_i,
  input  logic [LA_W-1:0]   mshr_addr_i,
  input  logic              wbb_pend_i,
  input  logic              wbb_full_i,
  input  logic [LA_W-1:0]   wbb_addr_i,
  input  logic [LINE_W-1:0] wbb_line_i,
  input  logic              l2_ack_i,
  output logic              mshr_grant_o,
  output logic              wbb_grant_o,
  output logic              l2_req_o,
  output logic              l2_we_o,     // Write for a victim, read for a miss
  output logic [LA_W-1:0]   l2_addr_o,
  output logic [LINE_W-1:0] l2_wdata_o
);

  import l1d_pkg::*;

  l2_arb_state_e state_q;
  logic          pick_wbb, pick_mshr;

  // Victims first when the buffer is full or no read waits
  assign pick_wbb  = wbb_pend_i && (wbb_full_i || !mshr_pend_i);
  assign pick_mshr = mshr_pend_i && !pick_wbb;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      l2_we_o <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (pick_wbb || pick_mshr) begin
            state_q <= WAIT_ACK;
            l2_we_o <= pick_wbb;
          end
        end
        WAIT_ACK:     if (l2_ack_i) state_q <= WAIT_RELEASE;
        WAIT_RELEASE: if (!l2_ack_i) state_q <= IDLE;  // Four-phase return to zero
        default:      state_q <= IDLE;
      endcase
    end
  end

  // Address and data held stable for the whole request
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE) begin
      l2_addr_o  <= pick_wbb ? wbb_addr_i : mshr_addr_i;
      l2_wdata_o <= pick_wbb ? wbb_line_i : '0;
    end
  end

  assign l2_req_o     = (state_q == WAIT_ACK);
  assign mshr_grant_o = l2_req_o && l2_ack_i && !l2_we_o;  // First ack cycle only
  assign wbb_grant_o  = l2_req_o && l2_ack_i && l2_we_o;

endmodule

// File: hdl/miss_status_regs.sv
module miss_status_regs #(
  parameter int unsigned ENTRIES = l1d_pkg::MSHR_ENTRIES,
  parameter int unsigned LA_W    = l1d_pkg::TAG_W + l1d_pkg::IDX_W
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            alloc_i,      // Load miss accepted
  input  logic            fill_i,       // Fill accepted, frees its line
  input  logic [LA_W-1:0] line_addr_i,
  input  logic            grant_i,      // L2 took the oldest pending read
  output logic            full_o,
  output logic            pend_o,
  output logic [LA_W-1:0] pend_addr_o
);

  // Entry state: free (!valid), pending (valid, !sent), sent (valid, sent)
  logic [ENTRIES-1:0] valid_q, sent_q;
  logic [LA_W-1:0]    addr_q [ENTRIES];
  logic [ENTRIES-1:0] older_q [ENTRIES];  // older_q[i][j] set if i came before j
  logic [ENTRIES-1:0] match, pending, oldest, alloc_sel;

  always_comb begin
    for (int i = 0; i < ENTRIES; i++) begin
      match[i] = valid_q[i] && (addr_q[i] == line_addr_i);
    end
  end

  assign pending = valid_q & ~sent_q;
  // Lowest free slot, nothing when the line is already tracked
  assign alloc_sel = (alloc_i && !(|match)) ? (~valid_q & (valid_q + 1'b1)) : '0;

  // Oldest pending entry by the age matrix
  always_comb begin
    pend_addr_o = '0;
    for (int i = 0; i < ENTRIES; i++) begin
      oldest[i] = pending[i];
      for (int j = 0; j < ENTRIES; j++) begin
        if (j != i && pending[j] && !older_q[i][j]) begin
          oldest[i] = 1'b0;
        end
      end
      if (oldest[i]) begin
        pend_addr_o = addr_q[i];
      end
    end
  end

  assign pend_o = |pending;
  assign full_o = &valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      sent_q  <= '0;
      for (int i = 0; i < ENTRIES; i++) begin
        older_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < ENTRIES; i++) begin
        // New entry is younger than all others
        older_q[i] <= alloc_sel[i] ? '0 : (older_q[i] | alloc_sel);
        if (alloc_sel[i]) begin
          valid_q[i] <= 1'b1;
          sent_q[i]  <= 1'b0;
        end
        if (fill_i && match[i]) valid_q[i] <= 1'b0;
        if (grant_i && oldest[i]) sent_q[i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < ENTRIES; i++) begin
      if (alloc_sel[i]) addr_q[i] <= line_addr_i;
    end
  end

endmodule

// File: hdl/wb_victim_buffer.sv
module wb_victim_buffer #(
  parameter  int unsigned ENTRIES = l1d_pkg::WBB_ENTRIES,
  parameter  int unsigned LA_W    = l1d_pkg::TAG_W + l1d_pkg::IDX_W,
  parameter  int unsigned LINE_W  = l1d_pkg::LINE_WORDS * l1d_pkg::WORD_W,
  localparam int unsigned PTR_W   = (ENTRIES > 1) ? $clog2(ENTRIES) : 1
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              push_i,         // Dirty victim from the fill
  input  logic [LA_W-1:0]   push_addr_i,
  input  logic [LINE_W-1:0] push_line_i,
  input  logic [LA_W-1:0]   lookup_addr_i,  // Line of the current load
  input  logic              grant_i,        // L2 took the oldest entry
  output logic              full_o,
  output logic              hit_o,
  output logic [LINE_W-1:0] hit_line_o,
  output logic              pend_o,
  output logic [LA_W-1:0]   pend_addr_o,
  output logic [LINE_W-1:0] pend_line_o
);

  logic [ENTRIES-1:0] valid_q;
  logic [LA_W-1:0]    addr_q [ENTRIES];
  logic [LINE_W-1:0]  line_q [ENTRIES];
  logic [PTR_W-1:0]   wr_ptr_q, rd_ptr_q;

  // Forwarding to loads from any held victim
  always_comb begin
    hit_o      = 1'b0;
    hit_line_o = '0;
    for (int i = 0; i < ENTRIES; i++) begin
      if (valid_q[i] && (addr_q[i] == lookup_addr_i)) begin
        hit_o      = 1'b1;
        hit_line_o = line_q[i];
      end
    end
  end

  assign full_o      = &valid_q;
  assign pend_o      = valid_q[rd_ptr_q];  // Head of the FIFO goes to L2
  assign pend_addr_o = addr_q[rd_ptr_q];
  assign pend_line_o = line_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_i) begin
        valid_q[wr_ptr_q] <= 1'b1;
        wr_ptr_q <= (wr_ptr_q == PTR_W'(ENTRIES - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (grant_i) begin
        valid_q[rd_ptr_q] <= 1'b0;  // Slot reusable once L2 has it
        rd_ptr_q <= (rd_ptr_q == PTR_W'(ENTRIES - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  // Victim payload
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      addr_q[wr_ptr_q] <= push_addr_i;
      line_q[wr_ptr_q] <= push_line_i;
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# Builds the L1D stage D1 testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tb_l1d_stage_d1 -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_l1d_stage_d1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^SIMULATION PASSED$"; then
  exit 0
fi
exit 1

// File: vlog.f
hdl/l1d_pkg.sv
hdl/d1_lookup.sv
hdl/fifo_replacement.sv
hdl/miss_status_regs.sv
hdl/wb_victim_buffer.sv
hdl/l2_req_arbiter.sv
hdl/l1d_stage_d1.sv
dv/l1d_stage_d1_assert.sv
dv/tb_l1d_stage_d1.sv
